/* rtl/vdemux_macros.svh */
// video demux widths and defaults
// fixed by the console's multiplexed video bus,
// shared by the package and the RTL blocks

`ifndef VDEMUX_MACROS_SVH
`define VDEMUX_MACROS_SVH

////////////////////////////////////////
// bus and pixel widths
////////////////////////////////////////

// data bus width, also the width of one colour
`define VD_COLOR_W 7

// sync nibble carried on the sync cycle
`define VD_SYNC_W 4

// full pixel word, sync followed by red, green and blue
`define VD_PIXEL_W (`VD_SYNC_W + 3 * `VD_COLOR_W)

////////////////////////////////////////
// configuration reset defaults
////////////////////////////////////////

// deblur off after reset
`define VD_CFG_DEBLUR_RST 1'b0

// full 21-bit colour after reset
`define VD_CFG_15BIT_RST 1'b0

`endif

/* rtl/vdemux_pkg.sv */
// video demux types
// pixel word, the two views of the input word,
// configuration and detector status

`default_nettype none

`include "vdemux_macros.svh"

package vdemux_pkg;

  ////////////////////////////////////////
  // sync and pixel
  ////////////////////////////////////////

  // all sync lines active low, vsync on top
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  // one rebuilt pixel, 25 bits
  typedef struct packed {
    sync_t                  sync;
    logic [`VD_COLOR_W-1:0] red;
    logic [`VD_COLOR_W-1:0] green;
    logic [`VD_COLOR_W-1:0] blue;
  } pixel_t;

  // bus word, read as colour sample or as sync word
  typedef union packed {
    logic [`VD_COLOR_W-1:0] sample;
    struct packed {
      // upper bits carry nothing on a sync cycle
      logic [`VD_COLOR_W-`VD_SYNC_W-1:0] rsvd;
      sync_t                             sync;
    } sync_word;
  } d_word_u;

  ////////////////////////////////////////
  // configuration and status
  ////////////////////////////////////////

  typedef struct packed {
    logic deblur_en;
    logic mode_15bit;
  } demux_cfg_t;

  // frame_count wraps at 256
  typedef struct packed {
    logic       interlaced;
    logic [7:0] frame_count;
    logic       field_parity;
  } status_t;

endpackage

`default_nettype wire

/* rtl/phase_counter.sv */
// colour word phase counter
// numbers the red, green and blue words that follow
// each sync cycle as 1, 2 and 3, else 0

`timescale 1ns/100ps
`default_nettype none

module phase_counter (
  input  wire        VCLK,
  input  wire        reset_i,
  input  wire        nDSYNC_i,
  output logic [1:0] data_cnt_o
);

  ////////////////////////////////////////
  // word counter
  ////////////////////////////////////////

  // counter is still running, sync seen within the last three words
  logic counting;

  assign counting = (data_cnt_o != 2'd0);

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      data_cnt_o <= 2'd0;
    end else if (!nDSYNC_i) begin
      // sync cycle, red follows
      data_cnt_o <= 2'd1;
    end else if (counting) begin
      // 1 -> 2 -> 3 -> 0, wraps once
      data_cnt_o <= data_cnt_o + 2'd1;
    end else begin
      // hold until the next sync cycle
      // stray words on the bus are ignored here
      data_cnt_o <= 2'd0;
    end
  end

  // a sync cycle always restarts the count, even mid-group,
  // so a short group from the console cannot shift the
  // phase of the words that follow

  // the demultiplexer only decodes 1, 2 and 3
  // 0 marks idle words between groups

endmodule

`default_nettype wire

/* rtl/vmode_detect.sv */
// frame mode detector
// finds field starts on falling nvsync, decides progressive
// or interlaced from the line phase at each field start,
// and counts frames

`timescale 1ns/100ps
`default_nettype none

module vmode_detect (
  input  wire                     VCLK,
  input  wire                     reset_i,
  input  wire                     nDSYNC_i,
  input  wire vdemux_pkg::d_word_u D_i,
  output logic                    frame_start_o,
  output vdemux_pkg::status_t     status_o
);

  // sync nibble of the current bus word
  vdemux_pkg::sync_t sync_in;
  // nvsync of the previous sync word
  logic              prev_nvsync_q;
  // at least one field start seen since reset
  logic              seen_field_q;

  assign sync_in = D_i.sync_word.sync;

  ////////////////////////////////////////
  // field start
  ////////////////////////////////////////

  // cleared at reset so no start fires before nvsync was high
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      prev_nvsync_q <= 1'b0;
    end else if (!nDSYNC_i) begin
      prev_nvsync_q <= sync_in.nvsync;
    end
  end

  // falling nvsync against the previous sync word
  assign frame_start_o = ~nDSYNC_i & prev_nvsync_q & ~sync_in.nvsync;

  ////////////////////////////////////////
  // mode and frame counter
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      seen_field_q <= 1'b0;
      status_o     <= '0;
    end else if (frame_start_o) begin
      seen_field_q <= 1'b1;
      // interlaced fields alternate line phase at vsync
      // first field after reset has nothing to compare to
      status_o.interlaced   <= seen_field_q & (sync_in.nhsync != status_o.field_parity);
      // line phase of the field just started
      status_o.field_parity <= sync_in.nhsync;
      status_o.frame_count  <= status_o.frame_count + 8'd1;
    end
  end

endmodule

`default_nettype wire

/* rtl/demux_config.sv */
// demux configuration registers
// deblur enable and 15-bit mode, writable as one word,
// plus a registered copy of the detector status for readback

`include "vdemux_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module demux_config (
  input  wire                        VCLK,
  input  wire                        reset_i,
  input  wire                        cfg_we_i,
  input  wire vdemux_pkg::demux_cfg_t cfg_wdata_i,
  input  wire vdemux_pkg::status_t    status_i,
  output vdemux_pkg::demux_cfg_t     cfg_o,
  output vdemux_pkg::status_t        status_o
);

  ////////////////////////////////////////
  // configuration word
  ////////////////////////////////////////

  // written value visible the cycle after the write
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      cfg_o.deblur_en  <= `VD_CFG_DEBLUR_RST;
      cfg_o.mode_15bit <= `VD_CFG_15BIT_RST;
    end else if (cfg_we_i) begin
      cfg_o <= cfg_wdata_i;
    end
  end

  ////////////////////////////////////////
  // status readback
  ////////////////////////////////////////

  // all fields taken on the same edge
  // frame count and mode never read from different frames
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      status_o <= '0;
    end else begin
      status_o <= status_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/video_demux.sv */
// video demultiplexer
// splits the console stream into sync and red, green, blue,
// rebuilds the pixel word one group later, with optional
// deblur blanking in progressive mode and 15-bit truncation

`include "vdemux_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module video_demux (
  input  wire                        VCLK,
  input  wire                        reset_i,
  input  wire                        nDSYNC_i,
  input  wire vdemux_pkg::d_word_u    D_i,
  input  wire [1:0]                  data_cnt_i,
  input  wire vdemux_pkg::demux_cfg_t cfg_i,
  input  wire                        interlaced_i,
  input  wire                        frame_start_i,
  output vdemux_pkg::pixel_t         pixel_o
);

  // first stage, one sync word and its colour triple
  vdemux_pkg::pixel_t     stage_q;
  // deblur in effect, only for progressive fields
  logic                   do_deblur;
  // blanking toggle, high on pass cycles
  logic                   nblank_q;
  // colours move to the output on this sync cycle
  logic                   pass_rgb;
  // 15-bit mode in force for the current frame
  logic                   mode_15bit_q;
  // ncsync rising against the stored sync word
  logic                   rise_ncsync;
  // incoming colour after optional truncation
  logic [`VD_COLOR_W-1:0] color_in;

  // keep upper 5 bits, clear the lowest 2
  function automatic logic [`VD_COLOR_W-1:0] trunc_color(
    input logic [`VD_COLOR_W-1:0] sample,
    input logic                   cut
  );
    logic [`VD_COLOR_W-1:0] result;
    result = sample;
    if (cut) begin
      result = {sample[`VD_COLOR_W-1:2], 2'b00};
    end
    return result;
  endfunction

  assign do_deblur   = cfg_i.deblur_en & ~interlaced_i;
  assign rise_ncsync = ~stage_q.sync.ncsync & D_i.sync_word.sync.ncsync;
  assign pass_rgb    = nblank_q | ~do_deblur;
  assign color_in    = trunc_color(D_i.sample, mode_15bit_q);

  ////////////////////////////////////////
  // deblur blanking
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      nblank_q <= 1'b1;
    end else if (!nDSYNC_i) begin
      if (!do_deblur || rise_ncsync) begin
        // start of a line realigns the pass phase
        nblank_q <= 1'b1;
      end else begin
        nblank_q <= ~nblank_q;
      end
    end
  end

  ////////////////////////////////////////
  // 15-bit mode, once per frame
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      mode_15bit_q <= 1'b0;
    end else if (frame_start_i) begin
      mode_15bit_q <= cfg_i.mode_15bit;
    end
  end

  ////////////////////////////////////////
  // demux and output stage
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      stage_q <= '0;
      pixel_o <= vdemux_pkg::pixel_t'({`VD_PIXEL_W{1'b0}});
    end else if (!nDSYNC_i) begin
      // with deblur, sync follows the pixel clock of the output
      if (do_deblur) begin
        pixel_o.sync <= stage_q.sync;
      end
      // blanked pixel keeps the previous colours
      if (pass_rgb) begin
        pixel_o.red   <= stage_q.red;
        pixel_o.green <= stage_q.green;
        pixel_o.blue  <= stage_q.blue;
      end
      // new sync word
      stage_q.sync <= D_i.sync_word.sync;
    end else begin
      case (data_cnt_i)
        2'd1: stage_q.red <= color_in;
        2'd2: begin
          stage_q.green <= color_in;
          // without deblur, sync leads the colours by one group
          if (!do_deblur) begin
            pixel_o.sync <= stage_q.sync;
          end
        end
        2'd3: stage_q.blue <= color_in;
        // idle word, nothing to collect
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/video_frontend_top.sv */
// video front end top level
// phase counter, frame mode detector, configuration
// registers and the demultiplexer, wired together

`timescale 1ns/100ps
`default_nettype none

module video_frontend_top (
  input  wire                        VCLK,
  input  wire                        reset_i,
  input  wire                        nDSYNC_i,
  input  wire vdemux_pkg::d_word_u    D_i,
  input  wire                        cfg_we_i,
  input  wire vdemux_pkg::demux_cfg_t cfg_wdata_i,
  output vdemux_pkg::pixel_t         pixel_o,
  output vdemux_pkg::demux_cfg_t     cfg_o,
  output vdemux_pkg::status_t        status_o
);

  // colour word number, 1 to 3 after a sync cycle
  wire [1:0]                data_cnt;
  // one-cycle pulse on falling nvsync
  wire                      frame_start;
  // detector status, before the readback register
  wire vdemux_pkg::status_t det_status;

  ////////////////////////////////////////
  // stream decoding
  ////////////////////////////////////////

  phase_counter i_phase_counter (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .nDSYNC_i   (nDSYNC_i),
    .data_cnt_o (data_cnt)
  );

  vmode_detect i_vmode_detect (
    .VCLK          (VCLK),
    .reset_i       (reset_i),
    .nDSYNC_i      (nDSYNC_i),
    .D_i           (D_i),
    .frame_start_o (frame_start),
    .status_o      (det_status)
  );

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  // cfg_o also feeds the demultiplexer
  demux_config i_demux_config (
    .VCLK        (VCLK),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_wdata_i (cfg_wdata_i),
    .status_i    (det_status),
    .cfg_o       (cfg_o),
    .status_o    (status_o)
  );

  ////////////////////////////////////////
  // pixel rebuild
  ////////////////////////////////////////

  // interlaced taken unregistered, straight from the detector
  video_demux i_video_demux (
    .VCLK          (VCLK),
    .reset_i       (reset_i),
    .nDSYNC_i      (nDSYNC_i),
    .D_i           (D_i),
    .data_cnt_i    (data_cnt),
    .cfg_i         (cfg_o),
    .interlaced_i  (det_status.interlaced),
    .frame_start_i (frame_start),
    .pixel_o       (pixel_o)
  );

endmodule

`default_nettype wire

/* test/tb_stream_tasks.svh */
// console stream driver and pixel model
// sends pixels, lines and fields on the multiplexed bus
// and tracks the pixel word the front end should show

`ifndef TB_STREAM_TASKS_SVH
`define TB_STREAM_TASKS_SVH

////////////////////////////////////////
// model state after reset
////////////////////////////////////////

// sync word of the previous group
vdemux_pkg::sync_t        m_prev_sync = '0;
// sync nibble expected on pixel_o
vdemux_pkg::sync_t        m_sync_out  = '0;
// colours expected on pixel_o with red on top
logic [3*`VD_COLOR_W-1:0] m_rgb       = '0;
// colours collected for the next sync cycle
logic [3*`VD_COLOR_W-1:0] m_pending   = '0;
logic                     m_nblank    = 1'b1;
// 15-bit mode latched at the last field start
logic                     m_mode      = 1'b0;
logic                     m_seen      = 1'b0;
vdemux_pkg::status_t      m_status    = '0;
vdemux_pkg::demux_cfg_t   m_cfg       = {`VD_CFG_DEBLUR_RST, `VD_CFG_15BIT_RST};
// nvsync falls put on the bus
int                       falls_sent  = 0;
logic                     last_vsync_n = 1'b0;
// expected pixel after each sync cycle
vdemux_pkg::pixel_t       expected_q[$];

function automatic logic [`VD_COLOR_W-1:0] cut_color(input logic [`VD_COLOR_W-1:0] c);
  // 15-bit mode keeps 5 significant bits
  return m_mode ? (c & 7'b111_1100) : c;
endfunction

function automatic logic [`VD_COLOR_W-1:0] rand_color();
  logic [31:0] v;
  v = $urandom;
  return v[`VD_COLOR_W-1:0];
endfunction

// effects of one sync cycle with new sync word s and its colours
task automatic model_sync_cycle(input vdemux_pkg::sync_t s,
                                input logic [3*`VD_COLOR_W-1:0] rgb);
  logic               deblur;
  vdemux_pkg::pixel_t want;
  deblur = m_cfg.deblur_en & ~m_status.interlaced;
  // with deblur the sync word leaves one group late on the sync cycle
  if (deblur) begin
    m_sync_out = m_prev_sync;
  end
  if (!deblur || m_nblank) begin
    m_rgb = m_pending;
  end
  // pass phase restarts on rising ncsync
  if (!deblur || (!m_prev_sync.ncsync && s.ncsync)) begin
    m_nblank = 1'b1;
  end else begin
    m_nblank = ~m_nblank;
  end
  // field start on falling nvsync
  if (m_prev_sync.nvsync && !s.nvsync) begin
    m_status.interlaced   = m_seen & (s.nhsync != m_status.field_parity);
    m_status.field_parity = s.nhsync;
    m_status.frame_count  = m_status.frame_count + 8'd1;
    m_seen                = 1'b1;
    m_mode                = m_cfg.mode_15bit;
  end
  m_prev_sync = s;
  m_pending   = {cut_color(rgb[20:14]), cut_color(rgb[13:7]), cut_color(rgb[6:0])};
  want.sync = m_sync_out;
  {want.red, want.green, want.blue} = m_rgb;
  expected_q.push_back(want);
endtask

////////////////////////////////////////
// stream drivers
////////////////////////////////////////

// one sync cycle then red, green, blue
task automatic send_pixel(input vdemux_pkg::sync_t s, input logic [`VD_COLOR_W-1:0] r,
                          input logic [`VD_COLOR_W-1:0] g, input logic [`VD_COLOR_W-1:0] b);
  vdemux_pkg::d_word_u w;
  w = '0;
  w.sync_word.sync = s;
  @(posedge VCLK);
  nDSYNC_i <= 1'b0;
  D_i      <= w;
  @(posedge VCLK);
  nDSYNC_i  <= 1'b1;
  D_i.sample <= r;
  model_sync_cycle(s, {r, g, b});
  @(negedge VCLK);
  check_pixel();
  @(posedge VCLK);
  D_i.sample <= g;
  @(posedge VCLK);
  D_i.sample <= b;
  // without deblur the sync word moves once green is taken
  if (!(m_cfg.deblur_en & ~m_status.interlaced)) begin
    m_sync_out = m_prev_sync;
  end
  @(negedge VCLK);
  check_sync_status();
endtask

// csync low on the first pixel whose nhsync follows phase
task automatic send_line(input logic vsync_n, input logic phase, input int npix);
  vdemux_pkg::sync_t s;
  int                p;
  if (last_vsync_n && !vsync_n) begin
    falls_sent++;
  end
  last_vsync_n = vsync_n;
  for (p = 0; p < npix; p++) begin
    s.nvsync = vsync_n;
    s.nclamp = (p > 1);
    s.ncsync = (p != 0);
    s.nhsync = (p == 0) ? phase : 1'b1;
    send_pixel(s, rand_color(), rand_color(), rand_color());
  end
endtask

// first line carries the nvsync fall
task automatic send_field(input logic phase, input int nlines, input int npix);
  int l;
  send_line(1'b0, phase, npix);
  for (l = 1; l < nlines; l++) begin
    send_line(1'b1, 1'b0, npix);
  end
endtask

task automatic write_cfg(input vdemux_pkg::demux_cfg_t w);
  @(posedge VCLK);
  cfg_we_i    <= 1'b1;
  cfg_wdata_i <= w;
  @(negedge VCLK);
  // not taken before the edge
  expect_equal("cfg_o before write", 32'(cfg_o), 32'(m_cfg));
  @(posedge VCLK);
  cfg_we_i <= 1'b0;
  m_cfg = w;
  @(negedge VCLK);
  expect_equal("cfg_o after write", 32'(cfg_o), 32'(m_cfg));
endtask

`endif

/* test/tb_video_frontend.sv */
// video front end testbench
// drives the console stream with random colours and checks
// pixel word, configuration and status against a model

`include "vdemux_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_video_frontend;

  logic                   VCLK;
  logic                   reset_i;
  logic                   nDSYNC_i;
  vdemux_pkg::d_word_u    D_i;
  logic                   cfg_we_i;
  vdemux_pkg::demux_cfg_t cfg_wdata_i;
  vdemux_pkg::pixel_t     pixel_o;
  vdemux_pkg::demux_cfg_t cfg_o;
  vdemux_pkg::status_t    status_o;

  int          checks      = 0;
  int          errors      = 0;
  int          test_num    = 0;
  int          test_errors = 0;
  string       test_name;
  int          blank_base;
  int unsigned seed_val;
  // pixels whose colours on pixel_o did not change
  int                       held_pixels = 0;
  logic [3*`VD_COLOR_W-1:0] last_rgb    = '0;

  `include "tb_stream_tasks.svh"

  video_frontend_top i_video_frontend_top (
    .VCLK        (VCLK),
    .reset_i     (reset_i),
    .nDSYNC_i    (nDSYNC_i),
    .D_i         (D_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_wdata_i (cfg_wdata_i),
    .pixel_o     (pixel_o),
    .cfg_o       (cfg_o),
    .status_o    (status_o)
  );

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////

  initial begin
    VCLK = 1'b0;
    forever #50 VCLK = ~VCLK;
  end

  // whole run stays well under this
  initial begin
    for (int n = 0; n < 60000; n++) begin
      @(posedge VCLK);
    end
    $display("timeout: the stream tests did not finish within 60000 clock cycles");
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    checks++;
    assert (cond) else begin
      errors++;
      $display("FAIL %0t ns: %s does not hold", $time, what);
    end
  endtask

  // previous group is on the output one cycle after a sync cycle
  task automatic check_pixel();
    vdemux_pkg::pixel_t       want;
    logic [3*`VD_COLOR_W-1:0] rgb;
    want = expected_q.pop_front();
    rgb  = {pixel_o.red, pixel_o.green, pixel_o.blue};
    // colours kept from the previous pixel mark a blanked one
    if (rgb == last_rgb) begin
      held_pixels++;
    end
    last_rgb = rgb;
    expect_equal("pixel_o", 32'(pixel_o), 32'(want));
  endtask

  task automatic check_sync_status();
    expect_equal("pixel_o sync", 32'(pixel_o.sync), 32'(m_sync_out));
    expect_equal("status_o", 32'(status_o), 32'(m_status));
  endtask

  // polls until the frame counter reaches want
  task automatic wait_frame_count(input logic [7:0] want, input int max_cycles);
    int n;
    n = 0;
    while (status_o.frame_count != want && n < max_cycles) begin
      @(negedge VCLK);
      n++;
    end
    checks++;
    assert (status_o.frame_count == want) else begin
      errors++;
      $display("timeout: frame_count stayed at %0d while waiting for %0d",
               status_o.frame_count, want);
    end
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic report_test();
    if (errors == test_errors) begin
      $display("test %0d, %s: passed", test_num, test_name);
    end else begin
      $display("test %0d, %s: FAIL, %0d errors", test_num, test_name, errors - test_errors);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    reset_i     = 1'b1;
    nDSYNC_i    = 1'b1;
    D_i         = '0;
    cfg_we_i    = 1'b0;
    cfg_wdata_i = '0;
    seed_val    = $urandom(17877);

    start_test("reset and configuration");
    repeat (2) @(posedge VCLK);
    reset_i <= 1'b0;
    @(negedge VCLK);
    expect_equal("pixel_o after reset", 32'(pixel_o), 32'd0);
    expect_equal("cfg_o after reset", 32'(cfg_o), 32'(m_cfg));
    expect_equal("status_o after reset", 32'(status_o), 32'd0);
    write_cfg(2'b11);
    write_cfg(2'b00);
    report_test();

    start_test("plain pixels");
    repeat (3) send_field(1'b0, 3, 5);
    report_test();

    // mode written in the middle of a field
    start_test("15-bit mode");
    repeat (2) send_line(1'b1, 1'b0, 5);
    write_cfg(2'b01);
    repeat (2) send_line(1'b1, 1'b0, 5);
    repeat (2) send_field(1'b0, 3, 5);
    expect_equal("low colour bits",
                 32'({pixel_o.red[1:0], pixel_o.green[1:0], pixel_o.blue[1:0]}), 32'd0);
    report_test();

    start_test("deblur, progressive");
    write_cfg(2'b10);
    blank_base = held_pixels;
    repeat (2) send_field(1'b0, 3, 6);
    expect_true("colours held in progressive deblur", held_pixels > blank_base);
    report_test();

    // line phase alternates at each field start
    start_test("deblur, interlaced");
    send_field(1'b1, 3, 6);
    blank_base = held_pixels;
    send_field(1'b0, 3, 6);
    send_field(1'b1, 3, 6);
    expect_equal("status_o interlaced", 32'(status_o.interlaced), 32'd1);
    expect_equal("held pixels when interlaced", 32'(held_pixels - blank_base), 32'd0);
    report_test();

    start_test("frame count wrap");
    repeat (260) send_field(1'b0, 2, 2);
    wait_frame_count(8'(falls_sent % 256), 20);
    report_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
+incdir+test
rtl/vdemux_pkg.sv
rtl/phase_counter.sv
rtl/vmode_detect.sv
rtl/demux_config.sv
rtl/video_demux.sv
rtl/video_frontend_top.sv
test/tb_video_frontend.sv
